// File: sources.f
verilog/wb_types_pkg.sv
verilog/wb_ctl_pkg.sv
verilog/wb_stage.sv
verilog/arch_reg_file.sv
verilog/wbaq.sv
verilog/mem_arbiter.sv
verilog/data_mem.sv
verilog/wb_top.sv
sim/tb_wb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then decide on the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary -j 0 -Wno-fatal --top-module tb_wb_top -f sources.f -o tb_wb_top \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_wb_top > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0

// File: sim/tb_wb_top.sv
`timescale 1ns/10ps

module tb_wb_top;

    localparam int wbaq_depth = 4;
    localparam int mem_words  = 64;
    localparam int idx_w      = $clog2(mem_words);
    localparam int load_limit = 8;     // cycles from rd_req to rd_valid under contention
    localparam int wait_limit = 64;

    // slot kinds as {is_reg, is_seg, is_mem, wb}
    localparam logic [3:0] reg_wb   = 4'b1001;
    localparam logic [3:0] reg_nowb = 4'b1000;
    localparam logic [3:0] seg_wb   = 4'b0101;
    localparam logic [3:0] seg_nowb = 4'b0100;
    localparam logic [3:0] mem_wb   = 4'b0011;

    logic                   clk;
    logic                   rst_n;
    wb_types_pkg::wb_slot_t slots [4];
    wb_types_pkg::wb_uop_t  uop;
    logic                   valid_in;
    logic                   interrupt_in;
    logic                   valid_out;
    wb_types_pkg::addr_t    new_eip;
    logic                   is_resteer;
    logic                   final_ie_val;
    logic [3:0]             final_ie_type;
    logic                   halt;
    logic                   stall;
    wb_types_pkg::rsel_t    reg_rd_idx;
    wb_types_pkg::rsel_t    seg_rd_idx;
    logic [31:0]            reg_rd_data;
    logic [15:0]            seg_rd_data;
    logic                   rd_req;
    wb_types_pkg::addr_t    rd_addr;
    logic                   rd_valid;
    wb_types_pkg::word_t    rd_data;

    wb_types_pkg::word_t    mem_model [mem_words];   // expected memory contents
    integer                 seed;
    int                     stall_cycles;

    wb_top #(.wbaq_depth(wbaq_depth), .mem_words(mem_words)) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .slots         (slots),
        .uop           (uop),
        .valid_in      (valid_in),
        .interrupt_in  (interrupt_in),
        .valid_out     (valid_out),
        .new_eip       (new_eip),
        .is_resteer    (is_resteer),
        .final_ie_val  (final_ie_val),
        .final_ie_type (final_ie_type),
        .halt          (halt),
        .stall         (stall),
        .reg_rd_idx    (reg_rd_idx),
        .seg_rd_idx    (seg_rd_idx),
        .reg_rd_data   (reg_rd_data),
        .seg_rd_data   (seg_rd_data),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_fail();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at %0t ns", $time);
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            stop_fail();
        end
    endtask

    function automatic wb_types_pkg::word_t rand_word();
        rand_word = {$random(seed), $random(seed)};
    endfunction

    task automatic clear_inputs();
        for (int s = 0; s < 4; s++) begin
            slots[s] = '0;
        end
        uop            = '0;
        uop.br_correct = 1'b1;   // no resteer unless a test asks for one
        valid_in       = 1'b0;
        interrupt_in   = 1'b0;
    endtask

    task automatic put_slot(input int s, input logic [3:0] kind,
                            input wb_types_pkg::addr_t dest, input wb_types_pkg::word_t d);
        slots[s].is_reg = kind[3];
        slots[s].is_seg = kind[2];
        slots[s].is_mem = kind[1];
        slots[s].wb     = kind[0];
        slots[s].dest   = dest;
        slots[s].data   = d;
    endtask

    // byte b of a naturally aligned store lands in lane addr[2:0]+b
    task automatic model_store(input wb_types_pkg::addr_t a, input wb_types_pkg::word_t d,
                               input wb_types_pkg::size_t size);
        int nb;
        int lane;
        nb = 1 << size;
        for (int b = 0; b < nb; b++) begin
            lane = int'(a[2:0]) + b;
            mem_model[a[3 +: idx_w]][lane*8 +: 8] = d[b*8 +: 8];
        end
    endtask

    // starts at a falling edge and holds slots and uop through any stall
    task automatic issue_uop();
        int          n;
        logic [31:0] held;
        n        = 0;
        valid_in = 1'b1;
        #1;
        held = reg_rd_data;
        while (stall) begin
            check("valid_out during stall", 64'd0, valid_out);
            check("reg_rd_data during stall", held, reg_rd_data);
            if (n == wait_limit) begin
                $display("stall did not clear within %0d cycles", wait_limit);
                stop_fail();
            end
            n++;
            stall_cycles++;
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        valid_in = 1'b0;
    endtask

    task automatic store_quad(input wb_types_pkg::addr_t a, input wb_types_pkg::word_t d);
        clear_inputs();
        put_slot(0, mem_wb, a, d);
        uop.def_size = wb_ctl_pkg::size_quad;
        issue_uop();
        model_store(a, d, wb_ctl_pkg::size_quad);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (i_dut.st_req) begin
            if (n == wait_limit) begin
                $display("store queue still not empty after %0d cycles", wait_limit);
                stop_fail();
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic check_load(input wb_types_pkg::addr_t a);
        int n;
        n       = 0;
        rd_addr = a;
        rd_req  = 1'b1;
        @(negedge clk);
        while (!rd_valid) begin
            if (n == load_limit) begin
                $display("load from %h got no rd_valid within %0d cycles", a, load_limit);
                stop_fail();
            end
            n++;
            @(negedge clk);
        end
        rd_req = 1'b0;
        check($sformatf("rd_data from %h", a), mem_model[a[3 +: idx_w]], rd_data);
    endtask

    task automatic check_reg(input wb_types_pkg::rsel_t idx, input logic [31:0] exp);
        reg_rd_idx = idx;
        #1;
        check($sformatf("reg_rd_data[%0d]", idx), exp, reg_rd_data);
        @(negedge clk);
    endtask

    task automatic check_seg(input wb_types_pkg::rsel_t idx, input logic [15:0] exp);
        seg_rd_idx = idx;
        #1;
        check($sformatf("seg_rd_data[%0d]", idx), exp, seg_rd_data);
        @(negedge clk);
    endtask

    task automatic test_reg_seg();
        wb_types_pkg::word_t d [8];
        for (int i = 0; i < 8; i++) begin
            d[i] = rand_word();
        end
        clear_inputs();
        put_slot(0, reg_wb, 32'd1, d[0]);
        put_slot(1, seg_wb, 32'd2, d[1]);
        put_slot(2, reg_nowb, 32'd3, d[2]);
        put_slot(3, reg_wb, 32'd1, d[3]);    // same register as slot 0
        issue_uop();
        clear_inputs();
        put_slot(0, seg_wb, 32'd4, d[4]);
        put_slot(1, seg_wb, 32'd4, d[5]);
        put_slot(2, reg_wb, 32'd6, d[6]);
        put_slot(3, seg_nowb, 32'd5, d[7]);
        issue_uop();
        check_reg(3'd1, d[3][31:0]);
        check_reg(3'd3, 32'd0);
        check_reg(3'd6, d[6][31:0]);
        check_seg(3'd2, d[1][15:0]);
        check_seg(3'd4, d[5][15:0]);
        check_seg(3'd5, 16'd0);
    endtask

    task automatic test_store_size();
        wb_types_pkg::word_t d;
        store_quad(32'h40, rand_word());
        store_quad(32'h48, rand_word());
        store_quad(32'h50, rand_word());
        // slot 1 is the lowest memory slot and its override asks for two bytes
        d = rand_word();
        clear_inputs();
        put_slot(1, mem_wb, 32'h42, d);
        put_slot(3, mem_wb, 32'h48, rand_word());
        uop.size_ovr = 4'b0010;
        uop.def_size = wb_ctl_pkg::size_dword;
        issue_uop();
        model_store(32'h42, d, wb_ctl_pkg::size_word);
        d = rand_word();
        clear_inputs();
        put_slot(0, mem_wb, 32'h4c, d);
        uop.def_size = wb_ctl_pkg::size_dword;
        issue_uop();
        model_store(32'h4c, d, wb_ctl_pkg::size_dword);
        d = rand_word();
        clear_inputs();
        put_slot(2, mem_wb, 32'h50, d);
        uop.far_jmp  = 1'b1;                 // forces eight bytes
        uop.def_size = wb_ctl_pkg::size_byte;
        issue_uop();
        model_store(32'h50, d, wb_ctl_pkg::size_quad);
        d = rand_word();
        clear_inputs();
        put_slot(0, mem_wb, 32'h45, d);
        uop.size_ovr = 4'b0001;
        uop.def_size = wb_ctl_pkg::size_quad;
        issue_uop();
        model_store(32'h45, d, wb_ctl_pkg::size_byte);
        wait_drain();
        check_load(32'h40);
        check_load(32'h48);
        check_load(32'h50);
    endtask

    task automatic test_stall();
        wb_types_pkg::addr_t a;
        wb_types_pkg::word_t d;
        stall_cycles = 0;
        reg_rd_idx   = 3'd7;
        rd_addr      = 32'h58;    // load traffic elsewhere halves the drain rate
        rd_req       = 1'b1;
        for (int i = 0; i < 3 * wbaq_depth; i++) begin
            a = 32'h100 + 32'(i * 8);
            d = rand_word();
            clear_inputs();
            put_slot(0, mem_wb, a, d);
            put_slot(2, reg_wb, 32'd7, 64'(i + 1));
            uop.def_size = wb_ctl_pkg::size_quad;
            issue_uop();
            model_store(a, d, wb_ctl_pkg::size_quad);
        end
        rd_req = 1'b0;
        if (stall_cycles == 0) begin
            $display("stall never rose while the store queue was saturated");
            stop_fail();
        end
        check_reg(3'd7, 32'(3 * wbaq_depth));
        wait_drain();
        for (int i = 0; i < 3 * wbaq_depth; i++) begin
            check_load(32'h100 + 32'(i * 8));
        end
    endtask

    task automatic test_arbitration();
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    store_quad(32'h180 + 32'(i * 8), rand_word());
                end
            end
            begin
                for (int j = 0; j < 8; j++) begin
                    check_load(32'h100 + 32'(j * 8));
                end
            end
        join
        wait_drain();
        for (int i = 0; i < 8; i++) begin
            check_load(32'h180 + 32'(i * 8));
        end
    endtask

    task automatic test_control();
        logic [5:0]          k;
        logic [2:0]          t;
        wb_types_pkg::addr_t e;
        wb_types_pkg::addr_t f;
        logic [15:0]         sel;
        clear_inputs();
        for (int c = 0; c < 64; c++) begin
            k              = 6'(c);
            e              = $random(seed);
            f              = $random(seed);
            t              = 3'($random(seed));
            uop.eip        = e;
            uop.br_fip     = f;
            uop.ie_type    = t;
            valid_in       = k[0];
            uop.br_correct = k[1];
            uop.ie         = k[2];
            interrupt_in   = k[3];
            uop.halt       = k[4];
            uop.br_taken   = k[5];
            #1;
            check("valid_out", k[0], valid_out);
            check("new_eip", k[5] ? f : e, new_eip);
            check("is_resteer", k[0] & ~k[1], is_resteer);
            check("final_ie_val", k[2] | k[3], final_ie_val);
            check("final_ie_type", {k[3], t}, final_ie_type);
            check("halt", k[4] & k[0], halt);
            @(negedge clk);
        end
        // slot 1 carries the far pointer as selector:offset
        e   = $random(seed);
        sel = 16'($random(seed));
        clear_inputs();
        put_slot(1, reg_wb, 32'd2, {16'h0, sel, e});
        uop.far_jmp  = 1'b1;
        uop.br_taken = 1'b1;
        uop.br_fip   = $random(seed);
        #1;
        check("new_eip far jump", e, new_eip);
        @(negedge clk);
        issue_uop();
        check_reg(3'd2, {16'h0, sel});
    endtask

    initial begin
        seed         = 32'habee7966;
        rst_n        = 1'b0;
        rd_req       = 1'b0;
        rd_addr      = '0;
        reg_rd_idx   = '0;
        seg_rd_idx   = '0;
        stall_cycles = 0;
        clear_inputs();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check("rd_valid after reset", 64'd0, rd_valid);
        check("wbaq_full after reset", 64'd0, i_dut.wbaq_full);
        check("st_req after reset", 64'd0, i_dut.st_req);
        test_reg_seg();
        test_store_size();
        test_stall();
        test_arbitration();
        test_control();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: verilog/wb_top.sv
`timescale 1ns/10ps

module wb_top #(
    parameter int wbaq_depth = 4,
    parameter int mem_words  = 64
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  wb_types_pkg::wb_slot_t slots [4],
    input  wb_types_pkg::wb_uop_t  uop,
    input  logic                   valid_in,
    input  logic                   interrupt_in,
    output logic                   valid_out,
    output wb_types_pkg::addr_t    new_eip,
    output logic                   is_resteer,
    output logic                   final_ie_val,
    output logic [3:0]             final_ie_type,
    output logic                   halt,
    output logic                   stall,
    input  wb_types_pkg::rsel_t    reg_rd_idx,
    input  wb_types_pkg::rsel_t    seg_rd_idx,
    output logic [31:0]            reg_rd_data,
    output logic [15:0]            seg_rd_data,
    input  logic                   rd_req,
    input  wb_types_pkg::addr_t    rd_addr,
    output logic                   rd_valid,
    output wb_types_pkg::word_t    rd_data
);

    logic [3:0]             reg_ld;
    logic [3:0]             seg_ld;
    wb_types_pkg::rsel_t    wr_idx [4];
    wb_types_pkg::word_t    wr_data [4];
    logic                   push;
    wb_types_pkg::store_t   push_data;
    logic                   wbaq_full;
    logic                   st_req;
    wb_types_pkg::store_t   st_head;
    logic                   st_grant;
    wb_types_pkg::mem_req_t mem_req;
    logic                   mem_en;
    wb_types_pkg::word_t    mem_rdata;

    wb_stage i_stage (
        .slots         (slots),
        .uop           (uop),
        .valid_in      (valid_in),
        .interrupt_in  (interrupt_in),
        .wbaq_full     (wbaq_full),
        .valid_out     (valid_out),
        .reg_ld        (reg_ld),
        .seg_ld        (seg_ld),
        .wr_idx        (wr_idx),
        .wr_data       (wr_data),
        .push          (push),
        .push_data     (push_data),
        .new_eip       (new_eip),
        .is_resteer    (is_resteer),
        .final_ie_val  (final_ie_val),
        .final_ie_type (final_ie_type),
        .halt          (halt),
        .stall         (stall)
    );

    arch_reg_file i_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_ld      (reg_ld),
        .seg_ld      (seg_ld),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .reg_rd_idx  (reg_rd_idx),
        .seg_rd_idx  (seg_rd_idx),
        .reg_rd_data (reg_rd_data),
        .seg_rd_data (seg_rd_data)
    );

    wbaq #(.wbaq_depth(wbaq_depth)) i_wbaq (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (st_grant),     // a granted store leaves the queue
        .head      (st_head),
        .st_req    (st_req),
        .full      (wbaq_full)
    );

    mem_arbiter i_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .st_req    (st_req),
        .st_head   (st_head),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .mem_rdata (mem_rdata),
        .st_grant  (st_grant),
        .mem_req   (mem_req),
        .mem_en    (mem_en),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    data_mem #(.mem_words(mem_words)) i_mem (
        .clk     (clk),
        .mem_en  (mem_en),
        .mem_req (mem_req),
        .rdata   (mem_rdata)
    );

endmodule

// File: verilog/data_mem.sv
`timescale 1ns/10ps

module data_mem #(
    parameter int mem_words = 64
) (
    input  logic                   clk,
    input  logic                   mem_en,
    input  wb_types_pkg::mem_req_t mem_req,
    output wb_types_pkg::word_t    rdata
);

    localparam int idx_w = $clog2(mem_words);

    wb_types_pkg::word_t mem [mem_words];
    logic [idx_w-1:0]    idx;
    logic [7:0]          size_mask;
    logic [7:0]          strobe;
    wb_types_pkg::word_t wdata;

    assign idx = mem_req.addr[3 +: idx_w];    // 8-byte words

    always_comb begin
        case (mem_req.size)
            wb_ctl_pkg::size_byte:  size_mask = 8'h01;
            wb_ctl_pkg::size_word:  size_mask = 8'h03;
            wb_ctl_pkg::size_dword: size_mask = 8'h0f;
            wb_ctl_pkg::size_quad:  size_mask = 8'hff;
        endcase
        strobe = size_mask << mem_req.addr[2:0];
        wdata  = mem_req.data << {mem_req.addr[2:0], 3'b000};  // move into byte lanes
    end

    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_req.we) begin
                for (int b = 0; b < 8; b++) begin
                    if (strobe[b]) begin
                        mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
                    end
                end
            end else begin
                rdata <= mem[idx];
            end
        end
    end

endmodule

// File: verilog/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   st_req,
    input  wb_types_pkg::store_t   st_head,
    input  logic                   rd_req,
    input  wb_types_pkg::addr_t    rd_addr,
    input  wb_types_pkg::word_t    mem_rdata,
    output logic                   st_grant,
    output wb_types_pkg::mem_req_t mem_req,
    output logic                   mem_en,
    output logic                   rd_valid,
    output wb_types_pkg::word_t    rd_data
);

    wb_ctl_pkg::req_src_e last_grant;
    logic                 ld_pend;    // load read issued last cycle
    logic                 ld_ok;
    logic                 ld_grant;

    // the caller still holds rd_req while its data comes back
    assign ld_ok    = rd_req & ~ld_pend;
    assign st_grant = st_req & (~ld_ok | (last_grant == wb_ctl_pkg::src_load));
    assign ld_grant = ld_ok & ~st_grant;
    assign mem_en   = st_grant | ld_grant;

    always_comb begin
        mem_req.we = st_grant;
        if (st_grant) begin
            mem_req.addr = st_head.addr;
            mem_req.data = st_head.data;
            mem_req.size = st_head.size;
        end else begin
            mem_req.addr = rd_addr;
            mem_req.data = '0;
            mem_req.size = wb_ctl_pkg::size_quad;   // loads fetch the whole word
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_grant <= wb_ctl_pkg::src_load;
            ld_pend    <= 1'b0;
        end else begin
            if (st_grant) begin
                last_grant <= wb_ctl_pkg::src_store;
            end else if (ld_grant) begin
                last_grant <= wb_ctl_pkg::src_load;
            end
            ld_pend <= ld_grant;
        end
    end

    assign rd_valid = ld_pend;
    assign rd_data  = mem_rdata;  // data_mem output is already registered

endmodule

// File: verilog/wbaq.sv
`timescale 1ns/10ps

module wbaq #(
    parameter int wbaq_depth = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  wb_types_pkg::store_t push_data,
    input  logic                 pop,
    output wb_types_pkg::store_t head,
    output logic                 st_req,
    output logic                 full
);

    localparam int ptr_w = (wbaq_depth > 1) ? $clog2(wbaq_depth) : 1;
    localparam int cnt_w = $clog2(wbaq_depth + 1);

    typedef logic [ptr_w-1:0] ptr_t;
    typedef logic [cnt_w-1:0] cnt_t;

    wb_types_pkg::store_t q [wbaq_depth];
    ptr_t                 wr_ptr;
    ptr_t                 rd_ptr;
    cnt_t                 count;
    logic                 do_push;
    logic                 do_pop;

    // wrap for depths that are not a power of two
    function automatic ptr_t ptr_inc(input ptr_t p);
        ptr_inc = (p == ptr_t'(wbaq_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push = push & ~full;    // stage stalls before this matters
    assign do_pop  = pop & st_req;

    always_ff @(posedge clk) begin
        if (do_push) begin
            q[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + cnt_t'(do_push) - cnt_t'(do_pop);
        end
    end

    assign head   = q[rd_ptr];
    assign st_req = (count != '0);
    assign full   = (count == cnt_t'(wbaq_depth));

endmodule

// File: verilog/arch_reg_file.sv
`timescale 1ns/10ps

module arch_reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [3:0]          reg_ld,
    input  logic [3:0]          seg_ld,
    input  wb_types_pkg::rsel_t wr_idx [4],
    input  wb_types_pkg::word_t wr_data [4],
    input  wb_types_pkg::rsel_t reg_rd_idx,
    input  wb_types_pkg::rsel_t seg_rd_idx,
    output logic [31:0]         reg_rd_data,
    output logic [15:0]         seg_rd_data
);

    logic [31:0] gpr [8];    // EAX..EDI
    logic [15:0] sreg [8];   // ES, CS, SS, DS, FS, GS and spares

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 8; r++) begin
                gpr[r]  <= '0;
                sreg[r] <= '0;
            end
        end else begin
            // ports in ascending order, the last assignment sticks
            for (int p = 0; p < 4; p++) begin
                if (reg_ld[p]) begin
                    gpr[wr_idx[p]] <= wr_data[p][31:0];
                end
                if (seg_ld[p]) begin
                    sreg[wr_idx[p]] <= wr_data[p][15:0];
                end
            end
        end
    end

    assign reg_rd_data = gpr[reg_rd_idx];
    assign seg_rd_data = sreg[seg_rd_idx];

endmodule

// File: verilog/wb_stage.sv
`timescale 1ns/10ps

module wb_stage (
    input  wb_types_pkg::wb_slot_t slots [4],
    input  wb_types_pkg::wb_uop_t  uop,
    input  logic                   valid_in,
    input  logic                   interrupt_in,
    input  logic                   wbaq_full,
    output logic                   valid_out,
    output logic [3:0]             reg_ld,
    output logic [3:0]             seg_ld,
    output wb_types_pkg::rsel_t    wr_idx [4],
    output wb_types_pkg::word_t    wr_data [4],
    output logic                   push,
    output wb_types_pkg::store_t   push_data,
    output wb_types_pkg::addr_t    new_eip,
    output logic                   is_resteer,
    output logic                   final_ie_val,
    output logic [3:0]             final_ie_type,
    output logic                   halt,
    output logic                   stall
);

    logic [3:0]          mem_wb;      // slots that want a store
    wb_types_pkg::size_t st_size;
    wb_types_pkg::addr_t br_target;

    assign stall     = valid_in & wbaq_full & (|mem_wb);
    assign valid_out = valid_in & ~stall;
    assign push      = valid_out & (|mem_wb);

    // per-slot load enables and register write data
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            mem_wb[i]  = slots[i].is_mem & slots[i].wb;
            reg_ld[i]  = slots[i].is_reg & slots[i].wb & valid_out;
            seg_ld[i]  = slots[i].is_seg & slots[i].wb & valid_out;
            wr_idx[i]  = slots[i].dest[2:0];
            wr_data[i] = slots[i].data;
        end
        if (uop.far_jmp) begin
            wr_data[1] = {48'd0, slots[1].data[47:32]};  // CS selector from far pointer
        end
    end

    // store size, override first, then far jump, then default
    always_comb begin
        if (uop.size_ovr[wb_ctl_pkg::ovr_byte_bit]) begin
            st_size = wb_ctl_pkg::size_byte;
        end else if (uop.size_ovr[wb_ctl_pkg::ovr_word_bit]) begin
            st_size = wb_ctl_pkg::size_word;
        end else if (uop.size_ovr[wb_ctl_pkg::ovr_dword_bit]) begin
            st_size = wb_ctl_pkg::size_dword;
        end else if (uop.size_ovr[wb_ctl_pkg::ovr_quad_bit] || uop.far_jmp) begin
            st_size = wb_ctl_pkg::size_quad;
        end else begin
            st_size = uop.def_size;
        end
    end

    // lowest memory slot wins, so scan downward
    always_comb begin
        push_data = '0;
        for (int i = 3; i >= 0; i--) begin
            if (mem_wb[i]) begin
                push_data.addr = slots[i].dest;
                push_data.data = slots[i].data;
            end
        end
        push_data.size = st_size;
    end

    assign br_target = uop.far_jmp ? slots[1].data[31:0] : uop.br_fip;
    assign new_eip   = uop.br_taken ? br_target : uop.eip;

    assign is_resteer = valid_out & ~uop.br_correct;   // mispredict, refetch

    always_comb begin
        final_ie_val                         = uop.ie | interrupt_in;
        final_ie_type[2:0]                   = uop.ie_type;
        final_ie_type[wb_ctl_pkg::ie_ext_bit] = interrupt_in;
    end

    assign halt = uop.halt & valid_in;

endmodule

// File: verilog/wb_ctl_pkg.sv
package wb_ctl_pkg;

    // bit positions inside wb_uop_t.size_ovr
    localparam int ovr_byte_bit  = 0;
    localparam int ovr_word_bit  = 1;
    localparam int ovr_dword_bit = 2;
    localparam int ovr_quad_bit  = 3;

    // external interrupt marker in final_ie_type
    localparam int ie_ext_bit = 3;

    // access size codes
    localparam wb_types_pkg::size_t size_byte  = 2'd0;
    localparam wb_types_pkg::size_t size_word  = 2'd1;
    localparam wb_types_pkg::size_t size_dword = 2'd2;
    localparam wb_types_pkg::size_t size_quad  = 2'd3;

    // who got data_mem last
    typedef enum logic {
        src_store,
        src_load
    } req_src_e;

endpackage

// File: verilog/wb_types_pkg.sv
package wb_types_pkg;

    typedef logic [63:0] word_t;   // full result value
    typedef logic [31:0] addr_t;   // byte address or EIP
    typedef logic [2:0]  rsel_t;   // register / segment index
    typedef logic [1:0]  size_t;   // access size code, see wb_ctl_pkg

    // one result slot of a micro-op
    typedef struct packed {
        word_t data;
        addr_t dest;      // low 3 bits pick the register for reg/seg slots
        logic  is_reg;
        logic  is_seg;
        logic  is_mem;
        logic  wb;        // slot really writes back
    } wb_slot_t;

    // micro-op context shared by all slots
    typedef struct packed {
        addr_t      eip;
        addr_t      br_fip;      // taken target for near branches
        logic [3:0] size_ovr;    // one-hot store size override
        size_t      def_size;
        logic       br_taken;
        logic       br_correct;
        logic       ie;          // exception raised by the micro-op
        logic       far_jmp;
        logic       halt;
        logic [2:0] ie_type;
    } wb_uop_t;

    typedef struct packed {
        addr_t addr;
        word_t data;
        size_t size;
    } store_t;

    typedef struct packed {
        logic  we;
        addr_t addr;
        word_t data;
        size_t size;
    } mem_req_t;

endpackage
